/* src/mem_test_pkg.sv */
// Memory tester shared constants, command codes, state encodings and control word
package mem_test_pkg;

   // ========================================
   // Widths and sizes
   // ========================================
   localparam int DATA_W      = 64;
   localparam int REG_W       = 32;
   localparam int ADDR_W      = 6;
   localparam int REG_ADDR_W  = 2;
   localparam int TOTAL_WORDS = 64;
   localparam int BURST_WORDS = 8;
   localparam int BURST_CNT_W = $clog2(BURST_WORDS);
   localparam int NUM_TESTS   = 5;
   localparam int TEST_IDX_W  = 3;
   localparam int CMD_W       = 4;

   // Galois taps for the random pattern (x^32 + x^22 + x^2 + x + 1)
   localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

   // Memory controller commands
   localparam logic [CMD_W-1:0] CMD_NOP   = 4'b0000;
   localparam logic [CMD_W-1:0] CMD_WRITE = 4'b0100;
   localparam logic [CMD_W-1:0] CMD_READ  = 4'b0110;

   // Host register map
   localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 2'd0;
   localparam logic [REG_ADDR_W-1:0] REG_SEED   = 2'd1;
   localparam logic [REG_ADDR_W-1:0] REG_STATUS = 2'd2;

   // ========================================
   // Control register word
   // ========================================
   typedef union packed {
      logic [REG_W-1:0] raw;
      struct packed {
         logic [REG_W-NUM_TESTS-5:0] rsvd_hi;
         logic [NUM_TESTS-1:0]       test_en;
         logic [2:0]                 rsvd_lo;
         logic                       start;
      } fields;
   } ctrl_word_u;

   // Burst command FSM
   typedef enum logic [2:0] {
      BS_HOLD,
      BS_WRITE,
      BS_WRITE_DONE,
      BS_READ,
      BS_READ_DONE
   } burst_state_e;

   // Test selection FSM
   typedef enum logic [2:0] {
      TS_IDLE,
      TS_FIND_TEST,
      TS_WR_START,
      TS_WR,
      TS_RD_START,
      TS_RD,
      TS_DONE
   } test_state_e;

endpackage

/* src/pattern_gen.sv */
// Test pattern source with a seeded 32-bit Galois LFSR for the random test
`timescale 1ns/1ps

module pattern_gen (
   input  logic                                clk_0,
   input  logic                                reset_0,
   input  logic [mem_test_pkg::TEST_IDX_W-1:0] test_idx,
   input  logic                                pattern_load,
   input  logic                                word_step,
   input  logic [mem_test_pkg::REG_W-1:0]      rand_seed,
   output logic [mem_test_pkg::DATA_W-1:0]     pattern
);
   import mem_test_pkg::*;

   logic [31:0] lfsr;
   logic [31:0] lfsr_next;

   // Right-shift Galois form, taps applied when bit 0 falls out
   always_comb begin
      lfsr_next = {1'b0, lfsr[31:1]};
      if (lfsr[0]) begin
         lfsr_next = lfsr_next ^ LFSR_POLY;
      end
   end

   always_ff @(posedge clk_0) begin
      if (reset_0) begin
         lfsr <= 32'h1;
      end else if (pattern_load) begin
         // All-zero state would lock up
         lfsr <= (rand_seed == '0) ? 32'h1 : rand_seed;
      end else if (word_step) begin
         lfsr <= lfsr_next;
      end
   end

   // ========================================
   // Pattern select
   // ========================================
   always_comb begin
      case (test_idx)
         3'd0: pattern = '0;
         3'd1: pattern = '1;
         3'd2: pattern = {(DATA_W/8){8'h55}};
         3'd3: pattern = {(DATA_W/8){8'haa}};
         // Upper half twice, then lower half twice
         3'd4: pattern = {lfsr[31:16], lfsr[31:16], lfsr[15:0], lfsr[15:0]};
         default: pattern = '0;
      endcase
   end

endmodule

/* src/burst_sequencer.sv */
// Burst command FSM issuing write and read bursts over the tested region
`timescale 1ns/1ps

module burst_sequencer (
   input  logic                           clk_0,
   input  logic                           reset_0,
   input  logic                           phase_start,
   input  logic                           phase_is_read,
   input  logic                           cmd_ack,
   input  logic                           rd_data_valid,
   output logic [mem_test_pkg::CMD_W-1:0]  cmd,
   output logic [mem_test_pkg::ADDR_W-1:0] addr,
   output logic                           burst_done,
   output logic                           word_step,
   output logic                           phase_done
);
   import mem_test_pkg::*;

   burst_state_e           state;
   logic [BURST_CNT_W-1:0] word_cnt;
   logic                   last_word;
   logic                   last_burst;

   // One word moves per acked write cycle or per valid read beat
   assign word_step = (state == BS_WRITE && cmd_ack) ||
                      (state == BS_READ && rd_data_valid);

   assign last_word  = (word_cnt == BURST_CNT_W'(BURST_WORDS - 1));
   assign last_burst = (addr == ADDR_W'(TOTAL_WORDS - BURST_WORDS));

   always_ff @(posedge clk_0) begin
      if (reset_0) begin
         state      <= BS_HOLD;
         cmd        <= CMD_NOP;
         addr       <= '0;
         word_cnt   <= '0;
         burst_done <= 1'b0;
         phase_done <= 1'b0;
      end else begin
         phase_done <= 1'b0;
         case (state)
            BS_HOLD: begin
               cmd <= CMD_NOP;
               if (phase_start) begin
                  addr     <= '0;
                  word_cnt <= '0;
                  if (phase_is_read) begin
                     state <= BS_READ;
                     cmd   <= CMD_READ;
                  end else begin
                     state <= BS_WRITE;
                     cmd   <= CMD_WRITE;
                  end
               end
            end

            BS_WRITE, BS_READ: begin
               if (word_step) begin
                  word_cnt <= word_cnt + 1'b1;
                  if (last_word) begin
                     burst_done <= 1'b1;
                     cmd        <= CMD_NOP;
                     word_cnt   <= '0;
                     state      <= (state == BS_WRITE) ? BS_WRITE_DONE : BS_READ_DONE;
                  end
               end
            end

            BS_WRITE_DONE, BS_READ_DONE: begin
               burst_done <= 1'b0;
               // Memory releases the ack the cycle after burst_done
               if (!cmd_ack) begin
                  if (last_burst) begin
                     phase_done <= 1'b1;
                     state      <= BS_HOLD;
                  end else begin
                     addr <= addr + ADDR_W'(BURST_WORDS);
                     if (state == BS_WRITE_DONE) begin
                        state <= BS_WRITE;
                        cmd   <= CMD_WRITE;
                     end else begin
                        state <= BS_READ;
                        cmd   <= CMD_READ;
                     end
                  end
               end
            end

            default: begin
               state <= BS_HOLD;
               cmd   <= CMD_NOP;
            end
         endcase
      end
   end

   // Command must hold for the whole acked burst
   cmd_stable_during_ack: assert property (
      @(posedge clk_0) disable iff (reset_0)
      (cmd_ack && !burst_done) |=> (burst_done || $stable(cmd))
   );

endmodule

/* src/test_sequencer.sv */
// Test selection FSM with read-back compare and run pass/fail status
`timescale 1ns/1ps

module test_sequencer (
   input  logic                                clk_0,
   input  logic                                reset_0,
   input  logic                                test_start,
   input  logic [mem_test_pkg::NUM_TESTS-1:0]  test_en,
   input  logic                                phase_done,
   input  logic [mem_test_pkg::DATA_W-1:0]     rd_data,
   input  logic                                rd_data_valid,
   input  logic [mem_test_pkg::DATA_W-1:0]     pattern,
   output logic                                phase_start,
   output logic                                phase_is_read,
   output logic                                pattern_load,
   output logic [mem_test_pkg::TEST_IDX_W-1:0] test_idx,
   output logic                                done,
   output logic                                success,
   output logic                                busy
);
   import mem_test_pkg::*;

   test_state_e state;
   logic        fail;
   logic        last_test;

   assign busy      = (state != TS_IDLE);
   assign last_test = (test_idx == TEST_IDX_W'(NUM_TESTS - 1));

   // ========================================
   // Test walk
   // ========================================
   always_ff @(posedge clk_0) begin
      if (reset_0) begin
         state         <= TS_IDLE;
         test_idx      <= '0;
         phase_start   <= 1'b0;
         phase_is_read <= 1'b0;
         pattern_load  <= 1'b0;
         done          <= 1'b0;
         success       <= 1'b0;
      end else begin
         phase_start  <= 1'b0;
         pattern_load <= 1'b0;
         case (state)
            TS_IDLE: begin
               // Start requests only count when idle
               if (test_start) begin
                  state    <= TS_FIND_TEST;
                  test_idx <= '0;
                  done     <= 1'b0;
                  success  <= 1'b0;
               end
            end
            TS_FIND_TEST: begin
               if (test_en[test_idx]) begin
                  state <= TS_WR_START;
               end else if (last_test) begin
                  state <= TS_DONE;
               end else begin
                  test_idx <= test_idx + 1'b1;
               end
            end
            TS_WR_START: begin
               phase_start   <= 1'b1;
               phase_is_read <= 1'b0;
               pattern_load  <= 1'b1;
               state         <= TS_WR;
            end
            TS_WR: begin
               if (phase_done) begin
                  state <= TS_RD_START;
               end
            end
            TS_RD_START: begin
               phase_start   <= 1'b1;
               phase_is_read <= 1'b1;
               pattern_load  <= 1'b1;
               state         <= TS_RD;
            end
            TS_RD: begin
               if (phase_done) begin
                  if (last_test) begin
                     state <= TS_DONE;
                  end else begin
                     test_idx <= test_idx + 1'b1;
                     state    <= TS_FIND_TEST;
                  end
               end
            end
            TS_DONE: begin
               done    <= 1'b1;
               success <= !fail;
               state   <= TS_IDLE;
            end
            default: state <= TS_IDLE;
         endcase
      end
   end

   // Failure latch, cleared at each new run
   always_ff @(posedge clk_0) begin
      if (reset_0) begin
         fail <= 1'b0;
      end else if (state == TS_IDLE && test_start) begin
         fail <= 1'b0;
      end else if (state == TS_RD && rd_data_valid && rd_data != pattern) begin
         fail <= 1'b1;
      end
   end

   phase_only_when_busy: assert property (
      @(posedge clk_0) disable iff (reset_0)
      phase_start |-> busy
   );

endmodule

/* src/test_regs.sv */
// Host register block holding test control, LFSR seed and run status
`timescale 1ns/1ps

module test_regs (
   input  logic                                clk_0,
   input  logic                                reset_0,
   input  logic                                reg_req,
   input  logic                                reg_rd_wr_l,
   input  logic [mem_test_pkg::REG_ADDR_W-1:0] reg_addr,
   input  logic [mem_test_pkg::REG_W-1:0]      reg_wr_data,
   input  logic                                done,
   input  logic                                success,
   input  logic                                busy,
   input  logic [mem_test_pkg::TEST_IDX_W-1:0] curr_test_idx,
   output logic [mem_test_pkg::REG_W-1:0]      reg_rd_data,
   output logic                                reg_ack,
   output logic                                test_start,
   output logic [mem_test_pkg::NUM_TESTS-1:0]  test_en,
   output logic [mem_test_pkg::REG_W-1:0]      rand_seed
);
   import mem_test_pkg::*;

   ctrl_word_u       ctrl_wr;
   ctrl_word_u       ctrl_rd;
   logic             access;
   logic [REG_W-1:0] rd_mux;

   // New request seen, not yet acked
   assign access = reg_req && !reg_ack;

   always_comb begin
      ctrl_wr.raw = reg_wr_data;
      ctrl_rd     = '0;
      ctrl_rd.fields.test_en = test_en;
   end

   always_comb begin
      case (reg_addr)
         REG_CTRL:   rd_mux = ctrl_rd.raw;
         REG_SEED:   rd_mux = rand_seed;
         REG_STATUS: rd_mux = {{(REG_W-7){1'b0}}, curr_test_idx, 1'b0, busy, success, done};
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_0) begin
      if (reset_0) begin
         reg_ack    <= 1'b0;
         test_start <= 1'b0;
         test_en    <= '0;
         rand_seed  <= '0;
      end else begin
         reg_ack    <= access;
         test_start <= 1'b0;
         if (access && !reg_rd_wr_l) begin
            if (reg_addr == REG_CTRL) begin
               test_en    <= ctrl_wr.fields.test_en;
               test_start <= ctrl_wr.fields.start;
            end else if (reg_addr == REG_SEED) begin
               rand_seed <= reg_wr_data;
            end
         end
      end
   end

   // Read data lines up with the ack cycle
   always_ff @(posedge clk_0) begin
      if (access) begin
         reg_rd_data <= rd_mux;
      end
   end

   ack_single_cycle: assert property (
      @(posedge clk_0) disable iff (reset_0)
      reg_ack |=> !reg_ack
   );

endmodule

/* src/mem_test_top.sv */
// Memory tester top level joining registers, sequencers and pattern source
`timescale 1ns/1ps

module mem_test_top (
   input  logic                                clk_0,
   input  logic                                reset_0,
   input  logic                                cmd_ack,
   input  logic [mem_test_pkg::DATA_W-1:0]     rd_data,
   input  logic                                rd_data_valid,
   input  logic                                reg_req,
   input  logic                                reg_rd_wr_l,
   input  logic [mem_test_pkg::REG_ADDR_W-1:0] reg_addr,
   input  logic [mem_test_pkg::REG_W-1:0]      reg_wr_data,
   output logic [mem_test_pkg::CMD_W-1:0]      cmd,
   output logic [mem_test_pkg::ADDR_W-1:0]     addr,
   output logic                                burst_done,
   output logic [mem_test_pkg::DATA_W-1:0]     wr_data,
   output logic [mem_test_pkg::REG_W-1:0]      reg_rd_data,
   output logic                                reg_ack,
   output logic                                done,
   output logic                                success
);
   import mem_test_pkg::*;

   logic                  test_start;
   logic [NUM_TESTS-1:0]  test_en;
   logic [REG_W-1:0]      rand_seed;
   logic                  busy;
   logic [TEST_IDX_W-1:0] test_idx;
   logic                  phase_start;
   logic                  phase_is_read;
   logic                  phase_done;
   logic                  pattern_load;
   logic                  word_step;

   test_regs test_regs_inst (
      .clk_0(clk_0), .reset_0(reset_0),
      .reg_req(reg_req), .reg_rd_wr_l(reg_rd_wr_l), .reg_addr(reg_addr),
      .reg_wr_data(reg_wr_data), .done(done), .success(success), .busy(busy),
      .curr_test_idx(test_idx), .reg_rd_data(reg_rd_data), .reg_ack(reg_ack),
      .test_start(test_start), .test_en(test_en), .rand_seed(rand_seed)
   );

   test_sequencer test_sequencer_inst (
      .clk_0(clk_0), .reset_0(reset_0),
      .test_start(test_start), .test_en(test_en), .phase_done(phase_done),
      .rd_data(rd_data), .rd_data_valid(rd_data_valid), .pattern(wr_data),
      .phase_start(phase_start), .phase_is_read(phase_is_read),
      .pattern_load(pattern_load), .test_idx(test_idx),
      .done(done), .success(success), .busy(busy)
   );

   burst_sequencer burst_sequencer_inst (
      .clk_0(clk_0), .reset_0(reset_0),
      .phase_start(phase_start), .phase_is_read(phase_is_read),
      .cmd_ack(cmd_ack), .rd_data_valid(rd_data_valid),
      .cmd(cmd), .addr(addr), .burst_done(burst_done),
      .word_step(word_step), .phase_done(phase_done)
   );

   // Write data is the live pattern
   pattern_gen pattern_gen_inst (
      .clk_0(clk_0), .reset_0(reset_0),
      .test_idx(test_idx), .pattern_load(pattern_load), .word_step(word_step),
      .rand_seed(rand_seed), .pattern(wr_data)
   );

endmodule

/* tests/mem_model.sv */
// Behavioral burst memory with random read latency and a bit-flip fault input
`timescale 1ns/1ps

module mem_model (
   input  logic                            clk_0,
   input  logic                            reset_0,
   input  logic [mem_test_pkg::CMD_W-1:0]  cmd,
   input  logic [mem_test_pkg::ADDR_W-1:0] addr,
   input  logic                            burst_done,
   input  logic [mem_test_pkg::DATA_W-1:0] wr_data,
   input  logic                            fault_inject,
   output logic                            cmd_ack,
   output logic [mem_test_pkg::DATA_W-1:0] rd_data,
   output logic                            rd_data_valid
);
   import mem_test_pkg::*;

   // Word and bit that get corrupted while fault_inject is high
   localparam int FAULT_WORD = 21;
   localparam int FAULT_BIT  = 17;

   logic [DATA_W-1:0] mem [TOTAL_WORDS];
   integer            seed;
   int                wr_beat;
   int                rd_beat;
   int                gap;

   initial begin
      seed          = 94;
      cmd_ack       = 1'b0;
      rd_data       = '0;
      rd_data_valid = 1'b0;
      for (int i = 0; i < TOTAL_WORDS; i++) begin
         mem[i] = {2{32'hbad0_0000 | i}};
      end
   end

   // ========================================
   // Write side, one word per acked edge
   // ========================================
   always @(posedge clk_0) begin
      if (reset_0 || burst_done) begin
         wr_beat <= 0;
      end else if (cmd == CMD_WRITE && cmd_ack) begin
         if (fault_inject && int'(addr) + wr_beat == FAULT_WORD) begin
            mem[int'(addr) + wr_beat] <= wr_data ^ (DATA_W'(1) << FAULT_BIT);
         end else begin
            mem[int'(addr) + wr_beat] <= wr_data;
         end
         wr_beat <= wr_beat + 1;
      end
   end

   // ========================================
   // Ack and read return, driven on the falling edge
   // ========================================
   always @(negedge clk_0) begin
      if (reset_0 || burst_done) begin
         cmd_ack       <= 1'b0;
         rd_data_valid <= 1'b0;
         rd_beat       <= 0;
      end else if (!cmd_ack) begin
         // First read word lands 2 to 5 cycles after the ack
         if (cmd != CMD_NOP) begin
            cmd_ack <= 1'b1;
            rd_beat <= 0;
            gap     <= 1 + int'($unsigned($random(seed)) % 32'd4);
         end
      end else if (cmd == CMD_READ) begin
         rd_data_valid <= 1'b0;
         if (rd_beat < BURST_WORDS) begin
            if (gap > 0) begin
               gap <= gap - 1;
            end else begin
               rd_data       <= mem[int'(addr) + rd_beat];
               rd_data_valid <= 1'b1;
               rd_beat       <= rd_beat + 1;
               // Sometimes a one-cycle hole before the next beat
               gap           <= int'($unsigned($random(seed)) % 32'd2);
            end
         end
      end
   end

endmodule

/* tests/mem_test_tb.sv */
// Memory tester testbench with host register driver, write-stream checker and memory model
`timescale 1ns/1ps

module mem_test_tb;
   import mem_test_pkg::*;

   // 9 tests over four runs, 2 phases x 8 bursts x about 30 cycles each, plus margin
   localparam int MAX_CYCLES = 20000;

   logic                  clk_0;
   logic                  reset_0;
   logic                  cmd_ack;
   logic [DATA_W-1:0]     rd_data;
   logic                  rd_data_valid;
   logic                  reg_req;
   logic                  reg_rd_wr_l;
   logic [REG_ADDR_W-1:0] reg_addr;
   logic [REG_W-1:0]      reg_wr_data;
   logic [CMD_W-1:0]      cmd;
   logic [ADDR_W-1:0]     addr;
   logic                  burst_done;
   logic [DATA_W-1:0]     wr_data;
   logic [REG_W-1:0]      reg_rd_data;
   logic                  reg_ack;
   logic                  done;
   logic                  success;
   logic                  fault_inject;

   int                    cycles;
   int                    errors;
   int                    errors_at_start;
   int                    tests_run;
   int                    tests_failed;
   string                 cur_name;
   int                    run_list[$];
   logic [REG_W-1:0]      run_seed;
   int                    wr_count;
   logic [NUM_TESTS-1:0]  seen_mask;
   int                    exp_test;
   logic [DATA_W-1:0]     exp_wr;
   logic [ADDR_W-1:0]     exp_addr;

   mem_test_top mem_test_top_inst (
      .clk_0(clk_0), .reset_0(reset_0),
      .cmd_ack(cmd_ack), .rd_data(rd_data), .rd_data_valid(rd_data_valid),
      .reg_req(reg_req), .reg_rd_wr_l(reg_rd_wr_l), .reg_addr(reg_addr),
      .reg_wr_data(reg_wr_data), .cmd(cmd), .addr(addr), .burst_done(burst_done),
      .wr_data(wr_data), .reg_rd_data(reg_rd_data), .reg_ack(reg_ack),
      .done(done), .success(success)
   );

   mem_model mem_model_inst (
      .clk_0(clk_0), .reset_0(reset_0), .cmd(cmd), .addr(addr),
      .burst_done(burst_done), .wr_data(wr_data), .fault_inject(fault_inject),
      .cmd_ack(cmd_ack), .rd_data(rd_data), .rd_data_valid(rd_data_valid)
   );

   initial begin
      clk_0 = 1'b0;
      forever #5 clk_0 = ~clk_0;
   end

   always @(posedge clk_0) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   // ========================================
   // Reference model
   // ========================================
   function automatic logic [DATA_W-1:0] expected_word(input int test_idx,
                                                       input int word_number,
                                                       input logic [31:0] seed);
      logic [31:0] lfsr;
      logic        out_bit;
      lfsr = (seed == 32'd0) ? 32'd1 : seed;
      for (int n = 0; n < word_number; n++) begin
         out_bit = lfsr[0];
         lfsr    = lfsr >> 1;
         if (out_bit) lfsr = lfsr ^ 32'h8020_0003;
      end
      case (test_idx)
         0:       expected_word = '0;
         1:       expected_word = '1;
         2:       expected_word = {8{8'h55}};
         3:       expected_word = {8{8'haa}};
         default: expected_word = {lfsr[31:16], lfsr[31:16], lfsr[15:0], lfsr[15:0]};
      endcase
   endfunction

   // Which fixed pattern a write word looks like, 4 for anything else
   function automatic int pattern_class(input logic [DATA_W-1:0] w);
      if (w == '0) return 0;
      else if (w == '1) return 1;
      else if (w == {8{8'h55}}) return 2;
      else if (w == {8{8'haa}}) return 3;
      return 4;
   endfunction

   task automatic report_mismatch(input string what, input logic [DATA_W-1:0] exp,
                                  input logic [DATA_W-1:0] act);
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
   endtask

   task automatic begin_test(input string name);
      cur_name        = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == errors_at_start) begin
         $display("%s: ok", cur_name);
      end else begin
         tests_failed++;
         $display("%s: %0d error(s)", cur_name, errors - errors_at_start);
      end
   endtask

   // Write stream compare, one word per acked write edge
   always @(posedge clk_0) begin
      if (!reset_0 && cmd == CMD_WRITE && cmd_ack) begin
         if (wr_count / TOTAL_WORDS >= run_list.size()) begin
            errors++;
            $display("Unexpected write word %0d beyond the enabled tests in %s",
                     wr_count, cur_name);
         end else begin
            exp_test = run_list[wr_count / TOTAL_WORDS];
            exp_wr   = expected_word(exp_test, wr_count % TOTAL_WORDS, run_seed);
            if (wr_data !== exp_wr) begin
               report_mismatch($sformatf("write word %0d", wr_count), exp_wr, wr_data);
            end
            // Start word of the burst this word belongs to
            exp_addr = ADDR_W'((wr_count % TOTAL_WORDS) / BURST_WORDS * BURST_WORDS);
            if (addr !== exp_addr) begin
               report_mismatch($sformatf("write address %0d", wr_count), exp_addr, addr);
            end
         end
         seen_mask[pattern_class(wr_data)] = 1'b1;
         wr_count++;
      end
   end

   // ========================================
   // Host register access
   // ========================================
   task automatic reg_access(input logic rd, input logic [REG_ADDR_W-1:0] a,
                             input logic [REG_W-1:0] wd, output logic [REG_W-1:0] rdata,
                             output int lat);
      lat         = 0;
      reg_req     = 1'b1;
      reg_rd_wr_l = rd;
      reg_addr    = a;
      reg_wr_data = wd;
      do begin
         @(negedge clk_0);
         lat++;
      end while (reg_ack !== 1'b1);
      rdata = reg_rd_data;
      @(negedge clk_0);
      reg_req = 1'b0;
   endtask

   task automatic run_tests(input logic [NUM_TESTS-1:0] mask);
      ctrl_word_u       ctrl;
      logic [REG_W-1:0] unused_rd;
      int               lat;
      ctrl                = '0;
      ctrl.fields.test_en = mask;
      ctrl.fields.start   = 1'b1;
      run_list.delete();
      for (int i = 0; i < NUM_TESTS; i++) begin
         if (mask[i]) run_list.push_back(i);
      end
      wr_count  = 0;
      seen_mask = '0;
      reg_access(1'b0, REG_CTRL, ctrl.raw, unused_rd, lat);
      while (done !== 1'b1) @(negedge clk_0);
      if (wr_count != TOTAL_WORDS * run_list.size()) begin
         report_mismatch("write word count", TOTAL_WORDS * run_list.size(), wr_count);
      end
   endtask

   initial begin
      logic [REG_W-1:0] rdata;
      int               lat;
      reset_0         = 1'b1;
      reg_req         = 1'b0;
      reg_rd_wr_l     = 1'b1;
      reg_addr        = '0;
      reg_wr_data     = '0;
      fault_inject    = 1'b0;
      run_seed        = '0;
      cycles          = 0;
      errors          = 0;
      tests_run       = 0;
      tests_failed    = 0;
      wr_count        = 0;
      seen_mask       = '0;
      cur_name        = "reset";
      repeat (16) @(posedge clk_0);
      @(negedge clk_0);
      reset_0 = 1'b0;
      @(negedge clk_0);

      begin_test("reset_defaults");
      if (cmd !== CMD_NOP) report_mismatch("cmd", CMD_NOP, cmd);
      if (burst_done !== 1'b0) report_mismatch("burst_done", 0, burst_done);
      if (done !== 1'b0) report_mismatch("done", 0, done);
      reg_access(1'b1, REG_STATUS, '0, rdata, lat);
      if (rdata[0] !== 1'b0) report_mismatch("status done", 0, rdata[0]);
      if (lat != 1) report_mismatch("reg_ack latency", 1, lat);
      end_test();

      begin_test("all_patterns");
      run_tests(5'b11111);
      reg_access(1'b1, REG_STATUS, '0, rdata, lat);
      if (rdata[1:0] !== 2'b11) report_mismatch("status done and success", 2'b11, rdata[1:0]);
      if (rdata[6:4] !== 3'd4) report_mismatch("curr_test_idx", 4, rdata[6:4]);
      end_test();

      begin_test("tests_1_and_3");
      run_tests(5'b01010);
      if (success !== 1'b1) report_mismatch("success", 1, success);
      for (int i = 0; i < TOTAL_WORDS; i++) begin
         if (mem_model_inst.mem[i] !== {8{8'haa}}) begin
            report_mismatch($sformatf("memory word %0d", i), {8{8'haa}}, mem_model_inst.mem[i]);
         end
      end
      if (seen_mask !== 5'b01010) report_mismatch("write stream test set", 5'b01010, seen_mask);
      end_test();

      begin_test("random_seed");
      run_seed = 32'h1357_9bdf;
      reg_access(1'b0, REG_SEED, run_seed, rdata, lat);
      reg_access(1'b1, REG_SEED, '0, rdata, lat);
      if (rdata !== run_seed) report_mismatch("seed readback", run_seed, rdata);
      run_tests(5'b10000);
      if (success !== 1'b1) report_mismatch("success", 1, success);
      end_test();

      begin_test("fault_in_test_2");
      fault_inject = 1'b1;
      run_tests(5'b00100);
      fault_inject = 1'b0;
      reg_access(1'b1, REG_STATUS, '0, rdata, lat);
      if (rdata[1:0] !== 2'b01) report_mismatch("status done and success", 2'b01, rdata[1:0]);
      if (success !== 1'b0) report_mismatch("success", 0, success);
      end_test();

      $display("Summary: %0d run, %0d with errors, %0d errors in total",
               tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* all.f */
src/mem_test_pkg.sv
src/pattern_gen.sv
src/burst_sequencer.sv
src/test_sequencer.sv
src/test_regs.sv
src/mem_test_top.sv
tests/mem_model.sv
tests/mem_test_tb.sv

/* Makefile */
# Verilator build and run of the memory tester testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module mem_test_tb -Mdir obj_dir
	./obj_dir/Vmem_test_tb | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
